//--- hw/mandel_macros.svh
/* mandelbrot tile renderer constants
   number format, tile size, iteration limit and start view */
`ifndef MANDEL_MACROS_SVH
`define MANDEL_MACROS_SVH

// fixed-point number format
`define FP_WIDTH 25  // total bits
`define FP_INT   4   // integer bits incl sign
`define FP_FRAC  (`FP_WIDTH - `FP_INT)

// escape-time limit
`define ITER_MAX 63

// tile geometry in points
`define TILE_W 16
`define TILE_H 8

// start view in FP_WIDTH two's complement
`define X_START 25'h1B0_0000  // -2.5
`define Y_START 25'h1E0_0000  // -1.0i
`define STEP    25'h008_0000  // 0.25 and the widest step allowed

`endif

//--- hw/mandel_fp_pkg.sv
/* fixed-point and iteration-count types of the escape-time datapath */
`include "mandel_macros.svh"

package mandel_fp_pkg;

    // signed fixed point with FP_INT integer bits incl sign
    typedef logic signed [`FP_WIDTH-1:0] fp_t;

    // full product width
    // squares of |z| up to 8 still fit here
    typedef logic signed [2*`FP_WIDTH-1:0] mul_t;

    // iteration count 0..ITER_MAX
    typedef logic [$clog2(`ITER_MAX+1)-1:0] iter_t;

endpackage

//--- hw/mandel_view_pkg.sv
/* navigation command encoding and tile point coordinates */
`include "mandel_macros.svh"

package mandel_view_pkg;

    typedef enum logic [2:0] {
        CMD_LEFT,
        CMD_RIGHT,
        CMD_UP,
        CMD_DOWN,
        CMD_ZOOM_IN,
        CMD_ZOOM_OUT,
        CMD_REDRAW
    } view_cmd_t;

    typedef logic [$clog2(`TILE_W)-1:0] tile_x_t;  // column in tile
    typedef logic [$clog2(`TILE_H)-1:0] tile_y_t;  // row in tile

endpackage

//--- hw/view_ctrl.sv
/* view controller
   four-phase command receiver, view register update with zoom limit, render start */
`timescale 1ns/1ps
`include "mandel_macros.svh"

module view_ctrl
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      cmd_req,
    input  view_cmd_t cmd,
    input  logic      render_busy,
    output logic      cmd_ack,
    output logic      cmd_err,
    output logic      render_start,
    output fp_t       x_start,
    output fp_t       y_start,
    output fp_t       step
);

    typedef enum logic [1:0] {ST_IDLE, ST_APPLY, ST_ACK} hs_state_t;

    hs_state_t state;
    view_cmd_t cmd_q;       // command taken from the bus
    logic      start_pend;  // reset frame not issued yet

    // candidate view for cmd_q
    fp_t  x_nx;
    fp_t  y_nx;
    fp_t  step_nx;
    logic view_ok;

    always_comb begin
        x_nx    = x_start;
        y_nx    = y_start;
        step_nx = step;
        case (cmd_q)
            CMD_LEFT:  x_nx = x_start - (step <<< 2);  // 4 steps
            CMD_RIGHT: x_nx = x_start + (step <<< 2);
            CMD_UP:    y_nx = y_start - (step <<< 2);
            CMD_DOWN:  y_nx = y_start + (step <<< 2);
            CMD_ZOOM_IN: begin
                // keep the centre roughly in place
                x_nx    = x_start + (step <<< 2);
                y_nx    = y_start + (step <<< 1);
                step_nx = step >>> 1;
            end
            CMD_ZOOM_OUT: begin
                x_nx    = x_start - (step <<< 3);
                y_nx    = y_start - (step <<< 2);
                step_nx = step <<< 1;
            end
            default: ;  // redraw leaves the view alone
        endcase
    end

    // only a zoom can fail this
    assign view_ok = (step_nx != '0) && (step_nx <= fp_t'(`STEP));

    always_ff @(posedge clk_sys) begin
        render_start <= 1'b0;  // single-cycle pulse
        if (rst_sys) begin
            state      <= ST_IDLE;
            cmd_ack    <= 1'b0;
            cmd_err    <= 1'b0;
            start_pend <= 1'b1;
            x_start    <= `X_START;
            y_start    <= `Y_START;
            step       <= `STEP;
        end else begin
            if (start_pend) begin  // first frame after reset
                render_start <= 1'b1;
                start_pend   <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    // hold off while a frame is in flight
                    if (cmd_req && !render_busy && !render_start && !start_pend) begin
                        cmd_q <= cmd;
                        state <= ST_APPLY;
                    end
                end
                ST_APPLY: begin
                    cmd_ack <= 1'b1;
                    cmd_err <= !view_ok;
                    if (view_ok) begin
                        x_start      <= x_nx;
                        y_start      <= y_nx;
                        step         <= step_nx;
                        render_start <= 1'b1;
                    end
                    state <= ST_ACK;
                end
                ST_ACK: begin
                    if (!cmd_req) begin  // requester has released
                        cmd_ack <= 1'b0;
                        cmd_err <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/mandel_iter.sv
/* escape-time iteration for one point
   one round per cycle with truncating fixed-point products */
`timescale 1ns/1ps
`include "mandel_macros.svh"

module mandel_iter
    import mandel_fp_pkg::*;
(
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  iter_start,
    input  fp_t   cx,
    input  fp_t   cy,
    output logic  iter_done,
    output iter_t iter_count
);

    localparam mul_t ESCAPE = mul_t'(4) <<< `FP_FRAC;  // |z|^2 bound of 4.0

    fp_t   cx_q;  // point under test
    fp_t   cy_q;
    fp_t   x;     // current z
    fp_t   y;
    iter_t cnt;   // rounds done so far
    logic  busy;

    mul_t xx;
    mul_t yy;
    mul_t xy;
    logic escaped;
    logic at_limit;

    always_comb begin
        // full-width products back to FP scale
        xx = (mul_t'(x) * mul_t'(x)) >>> `FP_FRAC;
        yy = (mul_t'(y) * mul_t'(y)) >>> `FP_FRAC;
        xy = (mul_t'(x) * mul_t'(y)) >>> `FP_FRAC;
        // compare before narrowing so large z cannot wrap
        escaped  = (xx + yy) > ESCAPE;
        at_limit = (cnt == iter_t'(`ITER_MAX));
    end

    always_ff @(posedge clk_sys) begin
        iter_done <= 1'b0;
        if (rst_sys) begin
            busy <= 1'b0;
        end else if (iter_start) begin
            busy <= 1'b1;
            x    <= '0;  // z0 = 0
            y    <= '0;
            cnt  <= '0;
            cx_q <= cx;
            cy_q <= cy;
        end else if (busy) begin
            if (escaped || at_limit) begin
                busy       <= 1'b0;
                iter_done  <= 1'b1;
                iter_count <= cnt;
            end else begin
                // z = z^2 + c
                x   <= fp_t'(xx - yy) + cx_q;
                y   <= fp_t'(xy <<< 1) + cy_q;
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/mandel_render.sv
/* tile renderer
   raster walk over the tile, builds point coordinates, feeds the iteration engine */
`timescale 1ns/1ps
`include "mandel_macros.svh"

module mandel_render
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
(
    input  logic    clk_sys,
    input  logic    rst_sys,
    input  logic    render_start,
    input  fp_t     x_start,
    input  fp_t     y_start,
    input  fp_t     step,
    input  logic    iter_done,
    input  iter_t   iter_count,
    input  logic    tx_ready,
    output logic    render_busy,
    output logic    iter_start,
    output fp_t     cx,
    output fp_t     cy,
    output logic    tx_load,
    output tile_x_t px,
    output tile_y_t py,
    output iter_t   pt_iter
);

    typedef enum logic [1:0] {RN_IDLE, RN_CALC, RN_HOLD, RN_LAST} rn_state_t;

    rn_state_t state;
    logic      row_end;  // px at right edge
    logic      last_pt;  // bottom right point

    assign row_end = (px == tile_x_t'(`TILE_W-1));
    assign last_pt = row_end && (py == tile_y_t'(`TILE_H-1));
    assign tx_load = (state == RN_HOLD) && tx_ready;  // hand over when sender is free

    always_ff @(posedge clk_sys) begin
        iter_start <= 1'b0;
        if (rst_sys) begin
            state       <= RN_IDLE;
            render_busy <= 1'b0;
        end else begin
            case (state)
                RN_IDLE: begin
                    if (render_start) begin
                        px          <= '0;
                        py          <= '0;
                        cx          <= x_start;  // top left point
                        cy          <= y_start;
                        iter_start  <= 1'b1;
                        render_busy <= 1'b1;
                        state       <= RN_CALC;
                    end
                end
                RN_CALC: begin
                    if (iter_done) begin
                        pt_iter <= iter_count;
                        state   <= RN_HOLD;
                    end
                end
                RN_HOLD: begin
                    if (tx_ready) begin  // tx_load this cycle
                        if (last_pt) begin
                            state <= RN_LAST;
                        end else begin
                            if (row_end) begin  // wrap to next row
                                px <= '0;
                                py <= py + 1'b1;
                                cx <= x_start;
                                cy <= cy + step;
                            end else begin
                                px <= px + 1'b1;
                                cx <= cx + step;
                            end
                            iter_start <= 1'b1;  // next point while this one is sent
                            state      <= RN_CALC;
                        end
                    end
                end
                RN_LAST: begin
                    // frame done once the last result has left
                    if (tx_ready) begin
                        render_busy <= 1'b0;
                        state       <= RN_IDLE;
                    end
                end
                default: state <= RN_IDLE;
            endcase
        end
    end

endmodule

//--- hw/pixel_tx.sv
/* result sender
   holds one (x, y, count) result and drives the four-phase output handshake */
`timescale 1ns/1ps

module pixel_tx
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
(
    input  logic    clk_sys,
    input  logic    rst_sys,
    input  logic    tx_load,
    input  tile_x_t px,
    input  tile_y_t py,
    input  iter_t   pt_iter,
    input  logic    pix_ack,
    output logic    tx_ready,
    output logic    pix_req,
    output tile_x_t pix_x,
    output tile_y_t pix_y,
    output iter_t   pix_iter
);

    typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_DRAIN} tx_state_t;

    tx_state_t state;

    assign tx_ready = (state == TX_IDLE);
    assign pix_req  = (state == TX_REQ);  // high until ack seen

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE:  if (tx_load) state <= TX_REQ;
                TX_REQ:   if (pix_ack) state <= TX_DRAIN;   // drop req next cycle
                TX_DRAIN: if (!pix_ack) state <= TX_IDLE;   // receiver released
                default:  state <= TX_IDLE;
            endcase
        end
    end

    // result register, stable for the whole handshake
    always_ff @(posedge clk_sys) begin
        if (tx_load && tx_ready) begin
            pix_x    <= px;
            pix_y    <= py;
            pix_iter <= pt_iter;
        end
    end

endmodule

//--- hw/mandel_tile_top.sv
/* mandelbrot tile core
   command receiver, raster renderer, iteration engine and result sender */
`timescale 1ns/1ps

module mandel_tile_top
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      cmd_req,
    input  view_cmd_t cmd,
    input  logic      pix_ack,
    output logic      cmd_ack,
    output logic      cmd_err,
    output logic      pix_req,
    output tile_x_t   pix_x,
    output tile_y_t   pix_y,
    output iter_t     pix_iter
);

    // view to renderer
    logic render_start;
    logic render_busy;
    fp_t  x_start;
    fp_t  y_start;
    fp_t  step;

    // renderer to iteration engine
    logic  iter_start;
    fp_t   cx;
    fp_t   cy;
    logic  iter_done;
    iter_t iter_count;

    // renderer to sender
    logic    tx_load;
    logic    tx_ready;
    tile_x_t px;
    tile_y_t py;
    iter_t   pt_iter;

    view_ctrl u_view (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .cmd_req(cmd_req),
        .cmd(cmd),
        .render_busy(render_busy),
        .cmd_ack(cmd_ack),
        .cmd_err(cmd_err),
        .render_start(render_start),
        .x_start(x_start),
        .y_start(y_start),
        .step(step)
    );

    mandel_render u_render (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .render_start(render_start),
        .x_start(x_start),
        .y_start(y_start),
        .step(step),
        .iter_done(iter_done),
        .iter_count(iter_count),
        .tx_ready(tx_ready),
        .render_busy(render_busy),
        .iter_start(iter_start),
        .cx(cx),
        .cy(cy),
        .tx_load(tx_load),
        .px(px),
        .py(py),
        .pt_iter(pt_iter)
    );

    mandel_iter u_iter (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .iter_start(iter_start),
        .cx(cx),
        .cy(cy),
        .iter_done(iter_done),
        .iter_count(iter_count)
    );

    pixel_tx u_tx (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .tx_load(tx_load),
        .px(px),
        .py(py),
        .pt_iter(pt_iter),
        .pix_ack(pix_ack),
        .tx_ready(tx_ready),
        .pix_req(pix_req),
        .pix_x(pix_x),
        .pix_y(pix_y),
        .pix_iter(pix_iter)
    );

endmodule

//--- bench/mandel_tile_chk.sv
/* handshake checker bound into the tile core
   output data hold, request hold, command ack and error framing */
`timescale 1ns/1ps

module mandel_tile_chk
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
(
    input logic    clk_sys,
    input logic    rst_sys,
    input logic    cmd_req,
    input logic    cmd_ack,
    input logic    cmd_err,
    input logic    pix_req,
    input logic    pix_ack,
    input tile_x_t pix_x,
    input tile_y_t pix_y,
    input iter_t   pix_iter
);

    // result held while the receiver has not answered
    a_pix_stable: assert property (@(posedge clk_sys) disable iff (rst_sys)
        pix_req && !pix_ack |=> $stable({pix_x, pix_y, pix_iter}))
        else $error("pix data changed before pix_ack");

    a_req_hold: assert property (@(posedge clk_sys) disable iff (rst_sys)
        pix_req && !pix_ack |=> pix_req)
        else $error("pix_req dropped without pix_ack");

    a_ack_rise: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose with cmd_req low");

    a_err_framed: assert property (@(posedge clk_sys) disable iff (rst_sys)
        cmd_err |-> cmd_ack)
        else $error("cmd_err high outside cmd_ack");

endmodule

bind mandel_tile_top mandel_tile_chk u_chk (
    .clk_sys(clk_sys),
    .rst_sys(rst_sys),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .cmd_err(cmd_err),
    .pix_req(pix_req),
    .pix_ack(pix_ack),
    .pix_x(pix_x),
    .pix_y(pix_y),
    .pix_iter(pix_iter)
);

//--- bench/mandel_tile_tb.sv
/* testbench for the mandelbrot tile core
   directed command tests, every frame checked against a fixed-point reference model */
`timescale 1ns/1ps
`include "mandel_macros.svh"

module mandel_tile_tb
    import mandel_fp_pkg::*;
    import mandel_view_pkg::*;
();

    localparam int FRAC          = `FP_WIDTH - `FP_INT;
    localparam int PIX_TIMEOUT   = 2000;   // well above the worst point of ~65 cycles
    localparam int CMD_TIMEOUT   = 40000;  // covers a whole stalled frame
    localparam int REJECT_WINDOW = 3000;

    logic      clk_sys;
    logic      rst_sys;
    logic      cmd_req;
    view_cmd_t cmd;
    logic      pix_ack;
    logic      cmd_ack;
    logic      cmd_err;
    logic      pix_req;
    tile_x_t   pix_x;
    tile_y_t   pix_y;
    iter_t     pix_iter;

    int     errors;
    int     results_seen;  // results taken since reset
    int     ack_seen_at;   // results_seen when the last cmd_ack rose
    bit     ack_delay_on;  // random pix_ack stall
    integer seed;

    // model view state
    fp_t vx;
    fp_t vy;
    fp_t vs;

    mandel_tile_top DUT (
        .clk_sys(clk_sys),
        .rst_sys(rst_sys),
        .cmd_req(cmd_req),
        .cmd(cmd),
        .pix_ack(pix_ack),
        .cmd_ack(cmd_ack),
        .cmd_err(cmd_err),
        .pix_req(pix_req),
        .pix_x(pix_x),
        .pix_y(pix_y),
        .pix_iter(pix_iter)
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;  // 40 ns period
    end

    // escape-time count for one point from z0 = 0
    function automatic int model_count(input fp_t cx, input fp_t cy);
        fp_t    x;
        fp_t    y;
        longint xx;
        longint yy;
        longint xy;
        int     n;
        bit     done;
        x    = '0;
        y    = '0;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            xx = (longint'(x) * longint'(x)) >>> FRAC;
            yy = (longint'(y) * longint'(y)) >>> FRAC;
            xy = (longint'(x) * longint'(y)) >>> FRAC;
            if ((xx + yy) > (longint'(4) <<< FRAC) || n == `ITER_MAX) begin
                done = 1'b1;
            end else begin
                x = fp_t'(xx - yy + longint'(cx));  // wraps like the 25-bit register
                y = fp_t'(2 * xy + longint'(cy));
                n++;
            end
        end
        return n;
    endfunction

    // navigation rule on the model view with 0 back for a rejected zoom
    function automatic bit update_view(input view_cmd_t c);
        longint nx;
        longint ny;
        longint ns;
        nx = vx;
        ny = vy;
        ns = vs;
        case (c)
            CMD_LEFT:  nx = vx - 4 * longint'(vs);
            CMD_RIGHT: nx = vx + 4 * longint'(vs);
            CMD_UP:    ny = vy - 4 * longint'(vs);
            CMD_DOWN:  ny = vy + 4 * longint'(vs);
            CMD_ZOOM_IN: begin
                nx = vx + 4 * longint'(vs);
                ny = vy + 2 * longint'(vs);
                ns = longint'(vs) / 2;
            end
            CMD_ZOOM_OUT: begin
                nx = vx - 8 * longint'(vs);
                ny = vy - 4 * longint'(vs);
                ns = 2 * longint'(vs);
            end
            default: ;  // redraw
        endcase
        if (ns == 0 || ns > longint'(fp_t'(`STEP))) begin
            return 1'b0;
        end
        vx = fp_t'(nx);
        vy = fp_t'(ny);
        vs = fp_t'(ns);
        return 1'b1;
    endfunction

    // error count, verdict and end of run
    task automatic finish_run;
        $display("checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic wait_pix_req(input bit level);
        int n;
        n = 0;
        @(negedge clk_sys);  // sample away from the active edge
        while (pix_req !== level) begin
            n++;
            if (n > PIX_TIMEOUT) begin
                $display("timeout while waiting for pix_req to become %0d", level);
                errors++;
                finish_run();
            end
            @(negedge clk_sys);
        end
    endtask

    task automatic wait_cmd_ack(input bit level, input int limit);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (cmd_ack !== level) begin
            n++;
            if (n > limit) begin
                $display("timeout while waiting for cmd_ack to become %0d", level);
                errors++;
                finish_run();
            end
            @(negedge clk_sys);
        end
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (results_seen < target) begin
            n++;
            if (n > CMD_TIMEOUT) begin
                $display("timeout while waiting for %0d results", target);
                errors++;
                finish_run();
            end
            @(negedge clk_sys);
        end
    endtask

    // four-phase command returning cmd_err as seen with cmd_ack high
    task automatic send_cmd(input view_cmd_t c, output bit err);
        @(posedge clk_sys);
        cmd     <= c;
        cmd_req <= 1'b1;
        wait_cmd_ack(1'b1, CMD_TIMEOUT);
        err         = cmd_err;
        ack_seen_at = results_seen;
        @(posedge clk_sys);
        cmd_req <= 1'b0;
        wait_cmd_ack(1'b0, 100);
    endtask

    // one frame of 128 results in raster order against the model
    task automatic collect_frame(input fp_t fx, input fp_t fy, input fp_t fs);
        int  px;
        int  py;
        int  exp_n;
        int  delay;
        fp_t cx;
        fp_t cy;
        for (py = 0; py < `TILE_H; py++) begin
            for (px = 0; px < `TILE_W; px++) begin
                cx    = fx + fp_t'(longint'(px) * longint'(fs));
                cy    = fy + fp_t'(longint'(py) * longint'(fs));
                exp_n = model_count(cx, cy);
                wait_pix_req(1'b1);
                results_seen++;
                assert (pix_x == tile_x_t'(px)) else begin
                    errors++;
                    $display("FAILED pix_x got 0x%h expected 0x%h", pix_x, tile_x_t'(px));
                end
                assert (pix_y == tile_y_t'(py)) else begin
                    errors++;
                    $display("FAILED pix_y got 0x%h expected 0x%h", pix_y, tile_y_t'(py));
                end
                assert (pix_iter == iter_t'(exp_n)) else begin
                    errors++;
                    $display("FAILED pix_iter at (%0d,%0d) got 0x%h expected 0x%h",
                             px, py, pix_iter, iter_t'(exp_n));
                end
                delay = ack_delay_on ? ($unsigned($random(seed)) % 8) : 0;
                repeat (delay) @(posedge clk_sys);  // receiver stall
                @(posedge clk_sys);
                pix_ack <= 1'b1;
                wait_pix_req(1'b0);
                @(posedge clk_sys);
                pix_ack <= 1'b0;
            end
        end
    endtask

    // command on model and DUT and its frame if accepted
    task automatic apply_cmd(input view_cmd_t c);
        bit ok;
        bit err;
        ok = update_view(c);
        send_cmd(c, err);
        assert (err == !ok) else begin
            errors++;
            $display("FAILED cmd_err for %s got 0x%h expected 0x%h", c.name(), err, !ok);
        end
        if (ok) begin
            collect_frame(vx, vy, vs);
        end
    endtask

    task automatic frame_after_reset;
        collect_frame(vx, vy, vs);  // frame issued by reset
    endtask

    task automatic reject_zoom_out;
        int n;
        bit seen;
        seen = 1'b0;
        apply_cmd(CMD_ZOOM_OUT);  // step already at its limit
        for (n = 0; n < REJECT_WINDOW; n++) begin
            @(negedge clk_sys);
            if (pix_req) seen = 1'b1;
        end
        assert (!seen) else begin
            errors++;
            $display("a result was sent after a rejected zoom");
        end
        apply_cmd(CMD_REDRAW);  // unchanged start view
    endtask

    task automatic move_around;
        apply_cmd(CMD_RIGHT);
        apply_cmd(CMD_DOWN);
        apply_cmd(CMD_LEFT);
        apply_cmd(CMD_UP);
    endtask

    task automatic zoom_in_and_out;
        apply_cmd(CMD_ZOOM_IN);
        apply_cmd(CMD_ZOOM_IN);
        apply_cmd(CMD_ZOOM_OUT);
        apply_cmd(CMD_REDRAW);
    endtask

    // command arrives mid-frame with a stalling receiver
    task automatic stall_mid_frame;
        fp_t ax;
        fp_t ay;
        fp_t as_;
        bit  ok;
        bit  err;
        int  base;
        ack_delay_on = 1'b1;
        ok = update_view(CMD_REDRAW);
        send_cmd(CMD_REDRAW, err);
        assert (err == !ok) else begin
            errors++;
            $display("FAILED cmd_err for CMD_REDRAW got 0x%h expected 0x%h", err, !ok);
        end
        ax   = vx;  // running frame view
        ay   = vy;
        as_  = vs;
        ok   = update_view(CMD_DOWN);  // model moves on to the pending view
        base = results_seen;
        fork
            begin
                collect_frame(ax, ay, as_);
                collect_frame(vx, vy, vs);
            end
            begin
                wait_results(base + 40);
                send_cmd(CMD_DOWN, err);
                assert (err == !ok) else begin
                    errors++;
                    $display("FAILED cmd_err got 0x%h expected 0x%h", err, !ok);
                end
                assert (ack_seen_at >= base + 128) else begin
                    errors++;
                    $display("cmd_ack came after only %0d results of the running frame",
                             ack_seen_at - base);
                end
            end
        join
        ack_delay_on = 1'b0;
    endtask

    initial begin
        seed         = 3;
        errors       = 0;
        results_seen = 0;
        ack_seen_at  = 0;
        ack_delay_on = 1'b0;
        rst_sys      = 1'b1;
        cmd_req      = 1'b0;
        cmd          = CMD_REDRAW;
        pix_ack      = 1'b0;
        vx           = `X_START;
        vy           = `Y_START;
        vs           = `STEP;
        repeat (10) @(posedge clk_sys);
        rst_sys <= 1'b0;
        frame_after_reset();
        reject_zoom_out();
        move_around();
        zoom_in_and_out();
        stall_mid_frame();
        finish_run();
    end

endmodule

//--- mandel_tile.f
+incdir+hw
hw/mandel_fp_pkg.sv
hw/mandel_view_pkg.sv
hw/view_ctrl.sv
hw/mandel_iter.sv
hw/mandel_render.sv
hw/pixel_tx.sv
hw/mandel_tile_top.sv
bench/mandel_tile_chk.sv
bench/mandel_tile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mandelbrot tile testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mandel_tile_tb \
    -f mandel_tile.f \
    -o Vmandel_tile_tb

./obj_dir/Vmandel_tile_tb | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
